// File: Bender.yml
package:
  name: mult_engine

sources:
  - files:
      - hw/mult_pkg.sv
      - hw/sync_fifo.sv
      - hw/math_mult_18.sv
      - hw/mult_issue.sv
      - hw/axil_mult_regs.sv
      - hw/mult_engine_top.sv
  - target: test
    files:
      - testbench/tb_mult_engine.sv

// File: hw/axil_mult_regs.sv
// AXI4-Lite register front end of the multiply engine
// operand writes push pairs, reads return status and products

module axil_mult_regs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // write address
  input  logic [mult_pkg::axil_addr_width-1:0]   awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  // write data
  input  logic [mult_pkg::axil_data_width-1:0]   wdata,
  input  logic [mult_pkg::axil_data_width/8-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  // write response
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  // read address
  input  logic [mult_pkg::axil_addr_width-1:0]   araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  // read data
  output logic [mult_pkg::axil_data_width-1:0]   rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  // operand buffer
  input  logic                                   op_full,
  input  logic                                   op_empty,
  output logic                                   op_push,
  output logic [mult_pkg::prod_width-1:0]        op_word,
  // result buffer
  input  logic                                   res_empty,
  input  logic [mult_pkg::res_cnt_width-1:0]     res_count,
  input  logic [mult_pkg::prod_width-1:0]        res_data,
  output logic                                   res_pop
);

  import mult_pkg::*;

  localparam int hi_width = prod_width - axil_data_width;

  wr_state_e                  wr_state;
  reg_addr_e                  wr_addr;
  reg_addr_e                  rd_addr;
  axil_resp_e                 wr_code;
  axil_resp_e                 rd_code;
  logic                       wr_ready;
  logic                       wr_fire;
  logic                       wr_is_a;
  logic                       wr_is_b;
  logic                       wr_stall;
  logic                       rd_fire;
  logic [op_a_width-1:0]      op_a_q;
  logic [axil_data_width-1:0] status_word;
  logic [axil_data_width-1:0] rd_word;

  ////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////

  // byte strobes not supported, every write is a full word
  assign wr_addr = reg_addr_e'(awaddr);

  always_comb begin
    wr_is_a = 1'b0;
    wr_is_b = 1'b0;
    wr_code = resp_slverr;
    case (wr_addr)
      reg_op_a: begin
        wr_is_a = 1'b1;
        wr_code = resp_okay;
      end
      reg_op_b: begin
        wr_is_b = 1'b1;
        wr_code = resp_okay;
      end
      default: ;
    endcase
  end

  // hold off a pair push until the operand FIFO has room
  assign wr_stall = wr_is_b && op_full;
  assign awready  = wr_ready;
  assign wready   = wr_ready;
  assign wr_fire  = wr_ready && awvalid && wvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= wr_idle;
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= resp_okay;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (wr_ready) begin
            // one-cycle ready pulse, then answer
            wr_ready <= 1'b0;
            bvalid   <= 1'b1;
            bresp    <= wr_code;
            wr_state <= wr_resp;
          end else if (awvalid && wvalid && !wr_stall) begin
            wr_ready <= 1'b1;
          end
        end
        wr_resp: begin
          if (bready) begin
            bvalid   <= 1'b0;
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // operand A waits here for its B
  always_ff @(posedge clk) begin
    if (wr_fire && wr_is_a)
      op_a_q <= wdata[op_a_width-1:0];
  end

  assign op_push = wr_fire && wr_is_b;
  assign op_word = {wdata[op_b_width-1:0], op_a_q};

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  assign rd_addr = reg_addr_e'(araddr);
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;

  always_comb begin
    status_word = '0;
    status_word[res_cnt_width-1:0] = res_count;
    status_word[8] = op_full;
    status_word[9] = op_empty;
  end

  // result reads on an empty buffer give zero and an error
  always_comb begin
    rd_word = '0;
    rd_code = resp_slverr;
    case (rd_addr)
      reg_status: begin
        rd_word = status_word;
        rd_code = resp_okay;
      end
      reg_res_lo: begin
        if (!res_empty) begin
          rd_word = res_data[axil_data_width-1:0];
          rd_code = resp_okay;
        end
      end
      reg_res_hi: begin
        if (!res_empty) begin
          rd_word = {{(axil_data_width-hi_width){res_data[prod_width-1]}},
                     res_data[prod_width-1:axil_data_width]};
          rd_code = resp_okay;
        end
      end
      default: ;
    endcase
  end

  assign res_pop = rd_fire && (rd_addr == reg_res_hi) && !res_empty;

  always_ff @(posedge clk) begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (rd_fire)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_code;
    end
  end

  // a write response is held until the host takes it
  assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid);

endmodule

// File: hw/math_mult_18.sv
// 25x18 multiplier, unsigned A times signed B
// three enabled register stages, registered 43-bit output

module math_mult_18 (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ena,
  input  logic        [mult_pkg::op_a_width-1:0] dina,
  input  logic signed [mult_pkg::op_b_width-1:0] dinb,
  output logic        [mult_pkg::prod_width-1:0] dout
);

  import mult_pkg::*;

  logic        [op_a_width-1:0]            a_reg;
  logic signed [op_b_width-1:0]            b_reg;
  logic        [prod_width-1:0]            m_reg;
  logic signed [op_a_width+op_b_width:0]   full_prod;

  // zero-extend A so it multiplies as a positive number
  assign full_prod = $signed({1'b0, a_reg}) * b_reg;

  // input, product and output stages, all held while ena is low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_reg <= '0;
      b_reg <= '0;
      m_reg <= '0;
      dout  <= '0;
    end else if (ena) begin
      a_reg <= dina;
      b_reg <= dinb;
      m_reg <= full_prod[prod_width-1:0];
      dout  <= m_reg;
    end
  end

endmodule

// File: hw/mult_engine_top.sv
// memory-mapped multiply engine
// AXI4-Lite front end, operand and result FIFOs, issue stage, multiplier

module mult_engine_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [mult_pkg::axil_addr_width-1:0]   awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [mult_pkg::axil_data_width-1:0]   wdata,
  input  logic [mult_pkg::axil_data_width/8-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [mult_pkg::axil_addr_width-1:0]   araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [mult_pkg::axil_data_width-1:0]   rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready
);

  import mult_pkg::*;

  // operand path
  logic                     op_push;
  logic [prod_width-1:0]    op_word;
  logic                     op_pop;
  logic [prod_width-1:0]    op_head;
  logic                     op_full;
  logic                     op_empty;

  // result path
  logic                     res_push;
  logic [prod_width-1:0]    res_word;
  logic                     res_pop;
  logic [prod_width-1:0]    res_head;
  logic                     res_empty;
  logic [res_cnt_width-1:0] res_count;

  // multiplier
  logic                         mult_ena;
  logic        [op_a_width-1:0] dina;
  logic signed [op_b_width-1:0] dinb;
  logic        [prod_width-1:0] dout;

  axil_mult_regs regs0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .op_full   (op_full),
    .op_empty  (op_empty),
    .op_push   (op_push),
    .op_word   (op_word),
    .res_empty (res_empty),
    .res_count (res_count),
    .res_data  (res_head),
    .res_pop   (res_pop)
  );

  sync_fifo #(
    .width (prod_width),
    .depth (op_fifo_depth)
  ) op_fifo0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (op_push),
    .push_data (op_word),
    .pop       (op_pop),
    .pop_data  (op_head),
    .full      (op_full),
    .empty     (op_empty),
    .count     ()
  );

  mult_issue issue0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_data   (op_head),
    .op_empty  (op_empty),
    .op_pop    (op_pop),
    .res_count (res_count),
    .dina      (dina),
    .dinb      (dinb),
    .mult_ena  (mult_ena),
    .prod      (dout),
    .res_push  (res_push),
    .res_data  (res_word)
  );

  math_mult_18 mult0 (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (mult_ena),
    .dina  (dina),
    .dinb  (dinb),
    .dout  (dout)
  );

  // credit check in the issue stage keeps this from overflowing
  sync_fifo #(
    .width (prod_width),
    .depth (res_fifo_depth)
  ) res_fifo0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_word),
    .pop       (res_pop),
    .pop_data  (res_head),
    .full      (),
    .empty     (res_empty),
    .count     (res_count)
  );

endmodule

// File: hw/mult_issue.sv
// issue stage between the operand FIFO and the multiplier
// pops pairs under a result credit check and pushes finished products

module mult_issue (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic        [mult_pkg::prod_width-1:0]    op_data,
  input  logic                                   op_empty,
  output logic                                   op_pop,
  input  logic        [mult_pkg::res_cnt_width-1:0] res_count,
  output logic        [mult_pkg::op_a_width-1:0]    dina,
  output logic signed [mult_pkg::op_b_width-1:0]    dinb,
  output logic                                   mult_ena,
  input  logic        [mult_pkg::prod_width-1:0]    prod,
  output logic                                   res_push,
  output logic        [mult_pkg::prod_width-1:0]    res_data
);

  import mult_pkg::*;

  logic [mult_latency-1:0]  vld_sr;
  logic [res_cnt_width-1:0] in_flight;
  logic [res_cnt_width:0]   used;
  logic                     credit_ok;

  // enable rises on the first cycle out of reset and stays up
  always_ff @(posedge clk) begin
    if (!rst_n)
      mult_ena <= 1'b0;
    else
      mult_ena <= 1'b1;
  end

  // operand word is {b, a}
  assign dina = op_data[op_a_width-1:0];
  assign dinb = op_data[op_a_width+op_b_width-1:op_a_width];

  ////////////////////////////////////////////////////////////
  // credit check
  ////////////////////////////////////////////////////////////

  // products still in the pipe, the one being pushed included
  assign in_flight = res_cnt_width'($countones(vld_sr));
  assign used      = {1'b0, res_count} + {1'b0, in_flight};
  assign credit_ok = (used < res_fifo_depth);

  assign op_pop = mult_ena && !op_empty && credit_ok;

  // valid bit rides alongside the multiplier stages
  always_ff @(posedge clk) begin
    if (!rst_n)
      vld_sr <= '0;
    else if (mult_ena)
      vld_sr <= {vld_sr[mult_latency-2:0], op_pop};
  end

  assign res_push = mult_ena && vld_sr[mult_latency-1];
  assign res_data = prod;

  // result buffer plus pipe never exceed the buffer size
  assert property (@(posedge clk) disable iff (!rst_n) used <= res_fifo_depth);

endmodule

// File: hw/mult_pkg.sv
// shared widths, depths and encodings for the multiply engine
// register map, AXI4-Lite response codes and write-channel states

package mult_pkg;

  ////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////

  // operand A unsigned, operand B signed
  localparam int op_a_width = 25;
  localparam int op_b_width = 18;

  // low bits of the two's-complement product
  localparam int prod_width = 43;

  // enabled cycles from dina/dinb to dout
  localparam int mult_latency = 3;

  ////////////////////////////////////////////////////////////
  // buffering
  ////////////////////////////////////////////////////////////

  localparam int op_fifo_depth  = 8;
  localparam int res_fifo_depth = 8;

  // occupancy counter width of the result buffer
  localparam int res_cnt_width = $clog2(res_fifo_depth + 1);

  ////////////////////////////////////////////////////////////
  // host port
  ////////////////////////////////////////////////////////////

  localparam int axil_addr_width = 5;
  localparam int axil_data_width = 32;

  typedef enum logic [axil_addr_width-1:0] {
    reg_op_a   = 5'h00,
    reg_op_b   = 5'h04,
    reg_status = 5'h08,
    reg_res_lo = 5'h0C,
    reg_res_hi = 5'h10
  } reg_addr_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  typedef enum logic {
    wr_idle,
    wr_resp
  } wr_state_e;

endpackage

// File: hw/sync_fifo.sv
// synchronous FIFO with a show-ahead read port
// circular buffer with full, empty and occupancy count

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic [width-1:0]           push_data,
  input  logic                       pop,
  output logic [width-1:0]           pop_data,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(depth+1)-1:0] count
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  logic [width-1:0]     mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic                 push_ok;
  logic                 pop_ok;

  // wrap at depth, so non power-of-two depths work too
  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop_ok)
        rd_ptr <= ptr_next(rd_ptr);
      if (push_ok && !pop_ok)
        count <= count + 1'b1;
      else if (pop_ok && !push_ok)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_ok)
      mem[wr_ptr] <= push_data;
  end

  // head word, shown ahead of the pop
  assign pop_data = mem[rd_ptr];
  assign full     = (count == depth);
  assign empty    = (count == '0);

  // the producer and consumer must respect the flags
  assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
  assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

// File: sim.f
hw/mult_pkg.sv
hw/sync_fifo.sv
hw/math_mult_18.sv
hw/mult_issue.sv
hw/axil_mult_regs.sv
hw/mult_engine_top.sv
testbench/tb_mult_engine.sv

// File: testbench/tb_mult_engine.sv
// testbench for the memory-mapped multiply engine
// AXI4-Lite stimulus, reference product model and in-order result checks

module tb_mult_engine;

  import mult_pkg::*;

  localparam int stream_pairs = 40;
  localparam int total_pairs  = stream_pairs + 2;
  localparam int clk_period   = 10;
  localparam int limit_cycles = total_pairs * 200 + 2000;

  logic                         clk;
  logic                         rst_n;
  logic [axil_addr_width-1:0]   awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [axil_data_width-1:0]   wdata;
  logic [axil_data_width/8-1:0] wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [axil_addr_width-1:0]   araddr;
  logic                         arvalid;
  logic                         arready;
  logic [axil_data_width-1:0]   rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;

  logic [prod_width-1:0] exp_q[$];
  logic [31:0]           got_lo_q[$];
  logic [31:0]           got_hi_q[$];
  logic [31:0]           lfsr_state;
  int                    pairs_written;
  int                    pairs_read;
  int                    stream_base;
  logic                  writer_done;

  mult_engine_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // error reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped after an error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // A zero-extended, B sign-extended, low 43 bits kept
  function automatic logic [prod_width-1:0] ref_product(input logic [24:0] a,
                                                        input logic [17:0] b);
    logic signed [63:0] a_ext;
    logic signed [63:0] b_ext;
    logic signed [63:0] p;
    a_ext = {39'd0, a};
    b_ext = {{46{b[17]}}, b};
    p = a_ext * b_ext;
    return p[prod_width-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // bus tasks, entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(negedge clk); while (!awready);
    assert (wready)
      else report_mismatch("wready did not rise together with awready");
    // handshake happens on the next rising edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    assert (!awready && !wready)
      else report_mismatch("write ready held longer than one cycle");
    while (!bvalid) @(negedge clk);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    assert (arready)
      else report_mismatch("arready low with no read data pending");
    do @(negedge clk); while (!rvalid);
    assert (!arready)
      else report_mismatch("arready high while rvalid is high");
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    rready  = 1'b1;
    @(negedge clk);
    rready  = 1'b0;
  endtask

  task automatic read_status(output logic [31:0] st);
    logic [1:0] resp;
    axil_read(reg_status, st, resp);
    assert (resp == mult_pkg::resp_okay)
      else report_mismatch("status read answered with an error");
  endtask

  task automatic write_pair(input logic [24:0] a, input logic [17:0] b);
    logic [1:0] resp;
    axil_write(reg_op_a, {7'd0, a}, resp);
    assert (resp == mult_pkg::resp_okay)
      else report_mismatch("write of operand A answered with an error");
    exp_q.push_back(ref_product(a, b));
    axil_write(reg_op_b, {14'd0, b}, resp);
    assert (resp == mult_pkg::resp_okay)
      else report_mismatch("write of operand B answered with an error");
    pairs_written++;
  endtask

  // waits for a product, then reads both halves and pops
  task automatic read_result();
    logic [31:0] st;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [1:0]  resp;
    read_status(st);
    while (st[3:0] == 4'd0)
      read_status(st);
    axil_read(reg_res_lo, lo, resp);
    assert (resp == mult_pkg::resp_okay)
      else report_mismatch("res_lo read answered with an error");
    axil_read(reg_res_hi, hi, resp);
    assert (resp == mult_pkg::resp_okay)
      else report_mismatch("res_hi read answered with an error");
    pairs_read++;
    got_lo_q.push_back(lo);
    got_hi_q.push_back(hi);
  endtask

  // finished and unread products, capped by the result buffer
  task automatic check_settled_count();
    logic [31:0] st;
    int          expect_cnt;
    int          polls;
    expect_cnt = pairs_written - pairs_read;
    if (expect_cnt > res_fifo_depth)
      expect_cnt = res_fifo_depth;
    polls = 0;
    read_status(st);
    while (int'(st[3:0]) != expect_cnt && polls < 32) begin
      read_status(st);
      polls++;
    end
    assert (int'(st[3:0]) == expect_cnt)
      else report_mismatch($sformatf("result count %0d, expected %0d", st[3:0], expect_cnt));
  endtask

  task automatic stream_writer();
    logic [24:0] a;
    logic [17:0] b;
    for (int i = 0; i < stream_pairs; i++) begin
      a = op_a_width'(rand_bits(op_a_width));
      b = op_b_width'(rand_bits(op_b_width));
      write_pair(a, b);
    end
    writer_done = 1'b1;
  endtask

  task automatic stream_reader();
    logic [31:0] st;
    read_status(st);
    while (!(st[8] && st[3:0] == 4'(res_fifo_depth)))
      read_status(st);
    // the writer should now be stuck on a B write
    repeat (20) @(negedge clk);
    assert (pairs_written - stream_base == op_fifo_depth + res_fifo_depth)
      else report_error("operand writes were not held off while both buffers were full");
    for (int i = 0; i < stream_pairs; i++) begin
      read_result();
      if (writer_done)
        check_settled_count();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checker and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : compare_results
    logic [prod_width-1:0] exp;
    logic [31:0]           lo;
    logic [31:0]           hi;
    logic [31:0]           exp_hi;
    forever begin
      wait (got_hi_q.size() > 0);
      lo = got_lo_q.pop_front();
      hi = got_hi_q.pop_front();
      assert (exp_q.size() > 0)
        else report_error("a product was read back with none expected");
      exp = exp_q.pop_front();
      // upper product bits as a signed value
      exp_hi = 32'($signed(exp) >>> axil_data_width);
      assert (lo == exp[31:0])
        else report_mismatch($sformatf("res_lo got %h, expected %h", lo, exp[31:0]));
      assert (hi == exp_hi)
        else report_mismatch($sformatf("res_hi got %h, expected %h", hi, exp_hi));
    end
  end

  initial begin : watchdog
    #(limit_cycles * clk_period);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] st;
    logic [31:0] st_before;
    logic [31:0] data;
    logic [1:0]  resp;
    logic [24:0] a5;
    logic [17:0] b5;
    clk           = 1'b0;
    rst_n         = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = 4'hF;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    lfsr_state    = 32'h38ee3d5e;
    pairs_written = 0;
    pairs_read    = 0;
    writer_done   = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // idle state after reset
    assert (!bvalid && !rvalid)
      else report_mismatch("bvalid or rvalid high after reset");
    read_status(st);
    assert (st == 32'h0000_0200)
      else report_mismatch($sformatf("status after reset %h", st));

    // corner pair, largest A and most negative B
    write_pair(25'h1FF_FFFF, 18'h2_0000);
    read_result();
    check_settled_count();

    // back-to-back stream against full buffers
    stream_base = pairs_written;
    fork
      stream_writer();
      stream_reader();
    join

    // error responses
    axil_read(reg_res_hi, data, resp);
    assert (resp == mult_pkg::resp_slverr && data == 32'd0)
      else report_mismatch("empty res_hi read did not return zero with an error");
    read_status(st_before);
    a5 = op_a_width'(rand_bits(op_a_width));
    b5 = op_b_width'(rand_bits(op_b_width));
    axil_write(reg_op_a, {7'd0, a5}, resp);
    axil_write(5'h14, 32'hDEAD_BEEF, resp);
    assert (resp == mult_pkg::resp_slverr)
      else report_mismatch("unmapped write did not answer with an error");
    axil_write(reg_status, 32'h1234_5678, resp);
    assert (resp == mult_pkg::resp_slverr)
      else report_mismatch("write to status did not answer with an error");
    read_status(st);
    assert (st == st_before)
      else report_mismatch($sformatf("status changed to %h after bad writes", st));
    exp_q.push_back(ref_product(a5, b5));
    axil_write(reg_op_b, {14'd0, b5}, resp);
    pairs_written++;
    read_result();
    check_settled_count();

    // let the checker drain
    wait (got_hi_q.size() == 0);
    @(negedge clk);
    if (exp_q.size() == 0 && got_hi_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d expected products were never read back", exp_q.size());
      abort_run();
    end
  end

endmodule
